/* verif/cpu_trace.txt */
// program word count, then the instruction words in order (pc = 4 * position)
// then expected csr value count, then the csr values in write order
00000043
// alu and immediate ops, each result written to the csr
06400093 ff900113 002081b3 51e19073
40208233 51e21073 00411293 51e29073
40115313 51e31073 01c15393 51e39073
00112433 51e41073 00113533 51e51073
0f017193 51e19073
// dependent chain, then register file bypass
00508193 00518193 00518193 51e19073
00900213 00100293 00520333 51e31073
// lui, store then load-use, auipc, csrrwi
123453b7 51e39073 00702423 00802403
51e41073 00001497 51e49073 04000593
51ead073
// six branch kinds, taken skips a bad csrrwi, not taken adds a bit
00108463 51efd073 00208463 00158593
00209463 51efd073 00109463 00258593
00114463 51efd073 0020c463 00458593
0020d463 51efd073 00115463 00858593
0020e463 51efd073 00116463 01058593
00117463 51efd073 0020f463 02058593
51e59073
// jal and jalr links, then a self loop
0080066f 51efd073 51e61073 010606e7
51efd073 51e69073 0000006f
// expected csr writes
00000011
0000005d 0000006b ffffff90 fffffffc
0000000f 00000001 00000000 000000f0
00000073 0000000a 12345000 12345000
0000107c 00000015 0000007f 000000f4
00000100

/* project.f */
source/riscv_pkg.sv
source/fetch_stage.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/writeback_unit.sv
source/cpu_top.sv
verif/clk_gen.sv
verif/cpu_props.sv
verif/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cpu -f project.f --Mdir obj_dir -o tb_cpu_sim

./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

/* verif/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

    localparam int IMEM_AWIDTH  = 10;
    localparam int DMEM_AWIDTH  = 10;
    localparam int TRACE_DEPTH  = 256;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 2000;  // cycles allowed per csr write
    localparam int QUIET_LIMIT  = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   prog_we;
    logic [IMEM_AWIDTH-1:0] prog_addr;
    logic [31:0]            prog_data;
    logic [31:0]            csr;
    logic                   csr_wr;

    logic [31:0] trace_mem [TRACE_DEPTH];
    int          n_prog;
    int          n_exp;
    int          value_errors;
    int          other_errors;
    logic        seen;
    logic        timed_out;

    clk_gen u_clk (.clk_o(clk));

    cpu_top #(
        .RESET_PC    (32'h0),
        .IMEM_AWIDTH (IMEM_AWIDTH),
        .DMEM_AWIDTH (DMEM_AWIDTH)
    ) u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .prog_we_i   (prog_we),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .csr_o       (csr),
        .csr_wr_o    (csr_wr)
    );

    task automatic check_csr(input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: csr_o is %08h, expected %08h", $time, actual, expected);
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: csr_wr_o is %b, expected %b", $time, actual, expected);
        end
    endtask

    // one clock in reset, optional program word, csr must stay quiet
    task automatic reset_cycle(input logic we, input logic [IMEM_AWIDTH-1:0] addr,
                               input logic [31:0] data);
        @(posedge clk);
        #2;
        prog_we   = we;
        prog_addr = addr;
        prog_data = data;
        @(negedge clk);
        check_csr(csr, 32'd0);
        check_strobe(csr_wr, 1'b0);
    endtask

    task automatic wait_csr_write(output logic found);
        found = 1'b0;
        for (int c = 0; c < WAIT_LIMIT && !found; c++) begin
            @(negedge clk);
            found = csr_wr;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        n_exp        = 0;

        $readmemh("verif/cpu_trace.txt", trace_mem);
        n_prog = trace_mem[0];
        if (n_prog > 0 && n_prog < TRACE_DEPTH - 1) begin
            n_exp = trace_mem[n_prog + 1];
        end

        if (n_prog <= 0 || n_prog > 2**IMEM_AWIDTH || n_exp <= 0 ||
            n_prog + n_exp + 2 > TRACE_DEPTH) begin
            other_errors++;
            $display("trace file verif/cpu_trace.txt is missing or malformed");
        end else begin
            for (int i = 0; i < n_prog; i++) begin
                reset_cycle(1'b1, IMEM_AWIDTH'(i), trace_mem[i + 1]);
            end
            for (int i = 0; i < RESET_CYCLES; i++) begin
                reset_cycle(1'b0, '0, '0);
            end
            @(posedge clk);
            #2;
            rst_n = 1'b1;

            for (int k = 0; k < n_exp && !timed_out; k++) begin
                wait_csr_write(seen);
                if (!seen) begin
                    timed_out = 1'b1;
                    other_errors++;
                    $display("csr write %0d of %0d never came within %0d cycles",
                             k + 1, n_exp, WAIT_LIMIT);
                end else begin
                    check_csr(csr, trace_mem[n_prog + 2 + k]);
                end
            end

            if (!timed_out) begin
                for (int c = 0; c < QUIET_LIMIT; c++) begin
                    @(negedge clk);
                    if (csr_wr) begin
                        other_errors++;
                        $display("extra csr write of %08h at %0t after the last expected one",
                                 csr, $time);
                    end
                end
            end
        end

        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verif/cpu_props.sv */
`timescale 1ns/100ps

module cpu_props (
    input logic                 clk,
    input logic                 rst_n_i,
    input riscv_pkg::id_ex_t    id_ex_i,
    input riscv_pkg::redirect_t redirect_i,
    input logic                 dmem_we_i,
    input logic                 csr_wr_i
);

    // csr strobe is a single-cycle pulse
    csr_strobe_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        csr_wr_i |=> !csr_wr_i)
        else $error("csr_wr_o high for two cycles in a row");

    // the word behind a taken transfer becomes a bubble
    redirect_flushes: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i.taken |=> !id_ex_i.valid)
        else $error("ID/EX entry still valid after a redirect");

    // a store in the squashed slot never reaches the data memory
    squashed_store_blocked: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i.taken |=> !dmem_we_i)
        else $error("dmem_we_o high for the squashed slot after a redirect");

endmodule

bind execute_unit cpu_props u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .id_ex_i    (id_ex_i),
    .redirect_i (redirect_o),
    .dmem_we_i  (dmem_we_o),
    .csr_wr_i   (csr_wr_o)
);

/* verif/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD = 10  // 20 ns clock
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
    parameter logic [31:0] RESET_PC    = 32'h0,
    parameter int          IMEM_AWIDTH = 10,
    parameter int          DMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   prog_we_i,
    input  logic [IMEM_AWIDTH-1:0] prog_addr_i,
    input  logic [31:0]            prog_data_i,
    output logic [31:0]            csr_o,
    output logic                   csr_wr_o
);
    import riscv_pkg::*;

    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        inst_valid;
    logic [4:0]  rs1, rs2;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] dmem_addr, dmem_wdata;
    logic        dmem_we;
    id_ex_t      id_ex;
    ex_wb_t      ex_wb;
    redirect_t   redirect;
    wb_t         wb;

    fetch_stage #(
        .RESET_PC    (RESET_PC),
        .IMEM_AWIDTH (IMEM_AWIDTH)
    ) u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .prog_we_i    (prog_we_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .inst_o       (inst),
        .pc_o         (inst_pc),
        .inst_valid_o (inst_valid)
    );

    decode_unit u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst),
        .pc_i         (inst_pc),
        .inst_valid_i (inst_valid),
        .flush_i      (redirect.taken),   // squash the word behind a taken transfer
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .id_ex_o      (id_ex)
    );

    reg_file u_rf (
        .clk        (clk),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_unit u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .id_ex_i      (id_ex),
        .wb_i         (wb),
        .redirect_o   (redirect),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .csr_o        (csr_o),
        .csr_wr_o     (csr_wr_o),
        .ex_wb_o      (ex_wb)
    );

    writeback_unit #(
        .DMEM_AWIDTH (DMEM_AWIDTH)
    ) u_writeback (
        .clk          (clk),
        .dmem_addr_i  (dmem_addr),
        .dmem_wdata_i (dmem_wdata),
        .dmem_we_i    (dmem_we),
        .ex_wb_i      (ex_wb),
        .wb_o         (wb)
    );

endmodule

/* source/writeback_unit.sv */
`timescale 1ns/100ps

module writeback_unit #(
    parameter int DMEM_AWIDTH = 10
) (
    input  logic              clk,
    input  logic [31:0]       dmem_addr_i,
    input  logic [31:0]       dmem_wdata_i,
    input  logic              dmem_we_i,
    input  riscv_pkg::ex_wb_t ex_wb_i,
    output riscv_pkg::wb_t    wb_o
);
    import riscv_pkg::*;

    logic [31:0] dmem [2**DMEM_AWIDTH];
    logic [31:0] rdata_q;
    logic [DMEM_AWIDTH-1:0] word_addr;

    assign word_addr = dmem_addr_i[DMEM_AWIDTH+1:2];  // byte offset ignored, word access only

    // read issued from execute, data lines up with the EX/WB entry
    always_ff @(posedge clk) begin
        if (dmem_we_i) begin
            dmem[word_addr] <= dmem_wdata_i;
        end
        rdata_q <= dmem[word_addr];
    end

    always_comb begin
        wb_o.we = ex_wb_i.valid && ex_wb_i.rf_we;
        wb_o.rd = ex_wb_i.rd;
        case (ex_wb_i.wb_sel)
            WB_MEM:  wb_o.data = rdata_q;
            WB_PC4:  wb_o.data = ex_wb_i.pc4;     // link address
            default: wb_o.data = ex_wb_i.alu_result;
        endcase
    end

endmodule

/* source/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  riscv_pkg::id_ex_t    id_ex_i,
    input  riscv_pkg::wb_t       wb_i,
    output riscv_pkg::redirect_t redirect_o,
    output logic [31:0]          dmem_addr_o,
    output logic [31:0]          dmem_wdata_o,
    output logic                 dmem_we_o,
    output logic [31:0]          csr_o,
    output logic                 csr_wr_o,
    output riscv_pkg::ex_wb_t    ex_wb_o
);
    import riscv_pkg::*;

    logic [31:0] rs1_val, rs2_val;
    logic [31:0] op_a, op_b;
    logic [31:0] alu_out;
    logic        br_cond;
    logic [31:0] csr_q;
    logic        csr_wr_q;
    ex_wb_t      ex_wb_d;
    ex_wb_t      ex_wb_q;

    // forward from writeback, x0 never forwarded
    assign rs1_val = (wb_i.we && wb_i.rd == id_ex_i.rs1 && id_ex_i.rs1 != 5'd0) ?
                     wb_i.data : id_ex_i.rs1_data;
    assign rs2_val = (wb_i.we && wb_i.rd == id_ex_i.rs2 && id_ex_i.rs2 != 5'd0) ?
                     wb_i.data : id_ex_i.rs2_data;

    assign op_a = id_ex_i.a_sel_pc ? id_ex_i.pc : rs1_val;
    assign op_b = id_ex_i.b_sel_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = 32'd0;
        endcase
    end

    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  br_cond = rs1_val == rs2_val;                     // beq
            3'b001:  br_cond = rs1_val != rs2_val;                     // bne
            3'b100:  br_cond = $signed(rs1_val) < $signed(rs2_val);    // blt
            3'b101:  br_cond = $signed(rs1_val) >= $signed(rs2_val);   // bge
            3'b110:  br_cond = rs1_val < rs2_val;                      // bltu
            3'b111:  br_cond = rs1_val >= rs2_val;                     // bgeu
            default: br_cond = 1'b0;
        endcase
    end

    assign redirect_o.taken  = id_ex_i.valid &&
                               (id_ex_i.is_jal || id_ex_i.is_jalr ||
                                (id_ex_i.is_branch && br_cond));
    assign redirect_o.target = id_ex_i.is_jalr ? ((rs1_val + id_ex_i.imm) & ~32'd1) :
                               id_ex_i.pc + id_ex_i.imm;

    // lw/sw address is rs1 + imm from the alu
    assign dmem_addr_o  = alu_out;
    assign dmem_wdata_o = rs2_val;
    assign dmem_we_o    = id_ex_i.valid && id_ex_i.mem_we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            csr_q    <= 32'd0;
            csr_wr_q <= 1'b0;
        end else begin
            csr_wr_q <= id_ex_i.valid && id_ex_i.csr_we;
            if (id_ex_i.valid && id_ex_i.csr_we) begin
                csr_q <= id_ex_i.csr_imm ? {27'd0, id_ex_i.rs1} : rs1_val;
            end
        end
    end

    assign csr_o    = csr_q;
    assign csr_wr_o = csr_wr_q;

    always_comb begin
        ex_wb_d.valid      = id_ex_i.valid;
        ex_wb_d.alu_result = id_ex_i.csr_we ? csr_q : alu_out;  // csr read returns old value
        ex_wb_d.pc4        = id_ex_i.pc4;
        ex_wb_d.rd         = id_ex_i.rd;
        ex_wb_d.rf_we      = id_ex_i.rf_we;
        ex_wb_d.wb_sel     = id_ex_i.wb_sel;
    end

    always_ff @(posedge clk) begin
        ex_wb_q <= ex_wb_d;
        if (!rst_n_i) begin
            ex_wb_q.valid <= 1'b0;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic           clk,
    input  logic [4:0]     rs1_i,
    input  logic [4:0]     rs2_i,
    input  riscv_pkg::wb_t wb_i,
    output logic [31:0]    rs1_data_o,
    output logic [31:0]    rs2_data_o
);

    logic [31:0] regs [1:31];  // no storage for x0

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.rd != 5'd0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle write is bypassed to the readers
    assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 :
                        (wb_i.we && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 :
                        (wb_i.we && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

endmodule

/* source/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [31:0]       inst_i,
    input  logic [31:0]       pc_i,
    input  logic              inst_valid_i,
    input  logic              flush_i,
    input  logic [31:0]       rs1_data_i,
    input  logic [31:0]       rs2_data_i,
    output logic [4:0]        rs1_o,
    output logic [4:0]        rs2_o,
    output riscv_pkg::id_ex_t id_ex_o
);
    import riscv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e     alu_op;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // bit 30 picks sub only for register ops, sra for both
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (opcode == OPC_OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = inst_i[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (opcode == OPC_LUI) begin
            alu_op = ALU_PASS_B;
        end
    end

    always_comb begin
        id_ex_d           = '0;
        id_ex_d.valid     = inst_valid_i;
        id_ex_d.pc        = pc_i;
        id_ex_d.pc4       = pc_i + 32'd4;
        id_ex_d.rs1_data  = rs1_data_i;
        id_ex_d.rs2_data  = rs2_data_i;
        id_ex_d.rs1       = rs1_o;
        id_ex_d.rs2       = rs2_o;
        id_ex_d.rd        = inst_i[11:7];
        id_ex_d.funct3    = funct3;
        id_ex_d.alu_op    = alu_op;
        id_ex_d.imm       = imm_i;
        id_ex_d.wb_sel    = WB_ALU;
        id_ex_d.b_sel_imm = 1'b1;
        case (opcode)
            OPC_LUI: begin
                id_ex_d.imm   = imm_u;
                id_ex_d.rf_we = 1'b1;
            end
            OPC_AUIPC: begin
                id_ex_d.imm      = imm_u;
                id_ex_d.a_sel_pc = 1'b1;
                id_ex_d.rf_we    = 1'b1;
            end
            OPC_JAL: begin
                id_ex_d.imm    = imm_j;
                id_ex_d.is_jal = 1'b1;
                id_ex_d.wb_sel = WB_PC4;
                id_ex_d.rf_we  = 1'b1;
            end
            OPC_JALR: begin
                id_ex_d.is_jalr = 1'b1;
                id_ex_d.wb_sel  = WB_PC4;
                id_ex_d.rf_we   = 1'b1;
            end
            OPC_BRANCH: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
                id_ex_d.b_sel_imm = 1'b0;
            end
            OPC_LOAD: begin
                id_ex_d.wb_sel = WB_MEM;  // lw only
                id_ex_d.rf_we  = 1'b1;
            end
            OPC_STORE: begin
                id_ex_d.imm    = imm_s;
                id_ex_d.mem_we = 1'b1;
            end
            OPC_OP_IMM: id_ex_d.rf_we = 1'b1;
            OPC_OP: begin
                id_ex_d.b_sel_imm = 1'b0;
                id_ex_d.rf_we     = 1'b1;
            end
            OPC_SYSTEM: begin
                // csrrw / csrrwi to the output csr, anything else is a nop
                if (funct3[1:0] == 2'b01 && inst_i[31:20] == CSR_ADDR) begin
                    id_ex_d.csr_we  = 1'b1;
                    id_ex_d.csr_imm = funct3[2];
                    id_ex_d.rf_we   = 1'b1;     // rd gets the old value
                end
            end
            default: ;
        endcase
        if (id_ex_d.rd == 5'd0) begin
            id_ex_d.rf_we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
        if (!rst_n_i || flush_i) begin
            id_ex_q.valid <= 1'b0;  // bubble
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC    = 32'h0,
    parameter int          IMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  riscv_pkg::redirect_t   redirect_i,
    input  logic                   prog_we_i,
    input  logic [IMEM_AWIDTH-1:0] prog_addr_i,
    input  logic [31:0]            prog_data_i,
    output logic [31:0]            inst_o,
    output logic [31:0]            pc_o,
    output logic                   inst_valid_o
);

    logic [31:0] imem [2**IMEM_AWIDTH];

    logic [31:0] pc_q;       // address being read this cycle
    logic [31:0] pc_next;
    logic [31:0] inst_q;
    logic [31:0] inst_pc_q;
    logic        valid_q;

    assign pc_next = redirect_i.taken ? redirect_i.target : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= !redirect_i.taken;  // word read in a redirect cycle is stale
        end
    end

    // synchronous read, program load only while in reset
    always_ff @(posedge clk) begin
        inst_q    <= imem[pc_q[IMEM_AWIDTH+1:2]];
        inst_pc_q <= pc_q;
        if (!rst_n_i && prog_we_i) begin
            imem[prog_addr_i] <= prog_data_i;
        end
    end

    assign inst_o       = inst_q;
    assign pc_o         = inst_pc_q;
    assign inst_valid_o = valid_q;

endmodule

/* source/riscv_pkg.sv */
package riscv_pkg;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    localparam logic [11:0] CSR_ADDR = 12'h51e;  // output csr (tohost)

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [2:0]  funct3;
        alu_op_e     alu_op;
        logic        a_sel_pc;
        logic        b_sel_imm;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic        mem_we;
        logic        csr_we;
        logic        csr_imm;    // csrrwi, operand is the rs1 field
        wb_sel_e     wb_sel;
        logic        rf_we;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_result;
        logic [31:0] pc4;
        logic [4:0]  rd;
        logic        rf_we;
        wb_sel_e     wb_sel;
    } ex_wb_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage
